/* compile.f */
+incdir+rtl
rtl/fspu_pkg.sv
rtl/fspu_decode.sv
rtl/fspu_fmt_lane.sv
rtl/fspu_result_pipe.sv
rtl/fspu_top.sv
verification/fspu_tb.sv

/* run.sh */
#!/bin/sh
# Build the FSPU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module fspu_tb -o fspu_sim

out=$(./obj_dir/fspu_sim)
echo "$out"

# Nonzero exit when the pass message is missing
echo "$out" | grep -q "STATUS: PASS"

/* verification/fspu_tb.sv */
//~~~~~~~~~~~~~~~~~~~~
// FSPU directed testbench
// Clock, reset and stimulus tasks
// Reference model of lanes and result pipe
// Immediate assertion checks, error count
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "fspu_cfg.svh"

module fspu_tb;

  // Operation codes of the reference model
  localparam int K_NONE   = 0;
  localparam int K_SGNJ   = 1;
  localparam int K_SGNJN  = 2;
  localparam int K_SGNJX  = 3;
  localparam int K_FMV_FX = 4;
  localparam int K_FMV_XF = 5;
  localparam int K_FCLASS = 6;
  localparam int TIMEOUT  = 20;

  logic                    ex1_pipe_clk;
  logic                    cpurst_b;
  logic [`FSPU_FUNC_W-1:0] func;
  logic [`FSPU_XLEN-1:0]   srcf0;
  logic [`FSPU_XLEN-1:0]   srcf1;
  logic [`FSPU_XLEN-1:0]   mtvr_src0;
  logic                    ex1_pipedown;
  logic                    ex2_pipedown;
  logic                    ex3_pipedown;
  logic                    fspu_forward_r_vld;
  logic [`FSPU_XLEN-1:0]   fspu_forward_result;
  logic [`FSPU_XLEN-1:0]   fspu_mfvr_data;

  int                      errors;
  int                      seed = 32'hd754d75b;
  // Expected EX2/EX3 contents and current EX1 float result
  logic [`FSPU_XLEN-1:0]   exp_ex2;
  logic [`FSPU_XLEN-1:0]   exp_ex3;
  logic [`FSPU_XLEN-1:0]   cur_freg;

  // FCLASS cases indexed by mask bit
  // Exponent kind 0 zero, 1 all ones, 2 normal
  // Mantissa kind 0 zero, 1 lsb only, 2 msb only
  int cls_sign [10] = '{1, 1, 1, 1, 0, 0, 0, 0, 0, 0};
  int cls_ek   [10] = '{1, 2, 0, 0, 0, 0, 2, 1, 1, 1};
  int cls_mk   [10] = '{0, 1, 1, 0, 0, 1, 1, 0, 1, 2};

  fspu_top UUT (
    .ex1_pipe_clk                 (ex1_pipe_clk),
    .cpurst_b                     (cpurst_b),
    .dp_vfalu_ex1_pipex_func      (func),
    .dp_vfalu_ex1_pipex_srcf0     (srcf0),
    .dp_vfalu_ex1_pipex_srcf1     (srcf1),
    .dp_vfalu_ex1_pipex_mtvr_src0 (mtvr_src0),
    .ex1_pipedown                 (ex1_pipedown),
    .ex2_pipedown                 (ex2_pipedown),
    .ex3_pipedown                 (ex3_pipedown),
    .fspu_forward_r_vld           (fspu_forward_r_vld),
    .fspu_forward_result          (fspu_forward_result),
    .fspu_mfvr_data               (fspu_mfvr_data)
  );

  // 100 ns clock
  initial
  begin
    ex1_pipe_clk = 1'b0;
    forever #50 ex1_pipe_clk = ~ex1_pipe_clk;
  end

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // Format 0 half, 1 single, 2 double
  function automatic int fmt_width(input int fmt);
    return 16 << fmt;
  endfunction

  function automatic int exp_width(input int fmt);
    return (fmt == 0) ? 5 : (fmt == 1) ? 8 : 11;
  endfunction

  function automatic logic [63:0] low_mask(input int fmt);
    return (fmt == 2) ? '1 : ((64'h1 << fmt_width(fmt)) - 64'h1);
  endfunction

  // One-hot func word for a format and operation
  function automatic logic [`FSPU_FUNC_W-1:0] make_func(input int fmt, input int op);
    logic [`FSPU_FUNC_W-1:0] f;
    f = '0;
    if (fmt == 2)
      f[`FSPU_FUNC_DOUBLE] = 1'b1;
    else if (fmt == 1)
      f[`FSPU_FUNC_SINGLE] = 1'b1;
    case (op)
      K_SGNJ:   f = f | (20'd1 << `FSPU_FUNC_SGNJ_GRP) | (20'd1 << `FSPU_FUNC_SEL0);
      K_SGNJN:  f = f | (20'd1 << `FSPU_FUNC_SGNJ_GRP) | (20'd1 << `FSPU_FUNC_SEL1);
      K_SGNJX:  f = f | (20'd1 << `FSPU_FUNC_SGNJ_GRP) | (20'd1 << `FSPU_FUNC_SEL2);
      K_FMV_FX: f = f | (20'd1 << `FSPU_FUNC_MV_GRP) | (20'd1 << `FSPU_FUNC_SEL0);
      K_FMV_XF: f = f | (20'd1 << `FSPU_FUNC_MV_GRP) | (20'd1 << `FSPU_FUNC_SEL2);
      K_FCLASS: f = f | (20'd1 << `FSPU_FUNC_CLASS);
      default:  f = f;
    endcase
    return f;
  endfunction

  // Float result NaN-boxed with ones
  // Zero for non-float ops
  function automatic logic [63:0] ref_freg(input int fmt, input int op,
                                           input logic [63:0] s0, input logic [63:0] s1,
                                           input logic [63:0] mv);
    logic [63:0] msk;
    logic [63:0] sb;
    logic [63:0] r;
    msk = low_mask(fmt);
    sb  = 64'h1 << (fmt_width(fmt) - 1);
    case (op)
      K_SGNJ:   r = (s0 & msk & ~sb) | (s1 & sb);
      K_SGNJN:  r = (s0 & msk & ~sb) | (~s1 & sb);
      K_SGNJX:  r = (s0 & msk) ^ (s1 & sb);
      K_FMV_FX: r = mv & msk;
      default:  return '0;
    endcase
    return r | ~msk;
  endfunction

  // FMV.X.F result as sign-extended low bits
  function automatic logic [63:0] ref_xf(input int fmt, input logic [63:0] s0);
    logic [63:0] msk;
    msk = low_mask(fmt);
    if (s0[fmt_width(fmt)-1])
      return (s0 & msk) | ~msk;
    return s0 & msk;
  endfunction

  // Operand for one FCLASS case with junk above the format width
  function automatic logic [63:0] make_fp(input int fmt, input int idx, input logic [63:0] junk);
    int          w;
    int          e;
    int          m;
    logic [63:0] expo;
    logic [63:0] mant;
    w = fmt_width(fmt);
    e = exp_width(fmt);
    m = w - 1 - e;
    expo = (cls_ek[idx] == 0) ? 64'h0 : (cls_ek[idx] == 1) ? ((64'h1 << e) - 64'h1) : 64'h1;
    mant = (cls_mk[idx] == 0) ? 64'h0 : (cls_mk[idx] == 1) ? 64'h1 : (64'h1 << (m - 1));
    return (junk & ~low_mask(fmt)) | (64'(cls_sign[idx]) << (w - 1)) | (expo << m) | mant;
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp)
    else
    begin
      errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // Advance one clock and the pipe model
  // EX3 checked at the falling edge
  task automatic tick();
    @(posedge ex1_pipe_clk);
    if (ex2_pipedown)
      exp_ex3 = exp_ex2;
    if (ex1_pipedown)
      exp_ex2 = cur_freg;
    @(negedge ex1_pipe_clk);
    check_val("fspu_forward_result", exp_ex3, fspu_forward_result);
  endtask

  // Drive one op at a falling edge
  // Integer result checked in the same cycle
  task automatic drive_op(input int fmt, input int op, input logic [63:0] s0,
                          input logic [63:0] s1, input logic [63:0] mv,
                          input logic [63:0] exp_int);
    func      = make_func(fmt, op);
    srcf0     = s0;
    srcf1     = s1;
    mtvr_src0 = mv;
    cur_freg  = ref_freg(fmt, op, s0, s1, mv);
    #10;
    check_val("fspu_mfvr_data", exp_int, fspu_mfvr_data);
  endtask

  // Bubbles behind the op until the value reaches EX3
  task automatic wait_forward(input logic [63:0] exp, input int edges);
    int n;
    n = 0;
    do
    begin
      tick();
      n++;
      func     = '0;
      cur_freg = '0;
    end
    while (fspu_forward_result !== exp && n < TIMEOUT);
    assert (fspu_forward_result === exp)
      check_val("fspu_forward_result latency", 64'(edges), 64'(n));
    else
    begin
      errors++;
      $display("Timed out after %0d cycles waiting for result %h", n, exp);
    end
  endtask

  task automatic test_reset();
    repeat (8) @(posedge ex1_pipe_clk);
    @(negedge ex1_pipe_clk);
    cpurst_b = 1'b1;
    #10;
    check_val("fspu_forward_result", '0, fspu_forward_result);
    check_val("fspu_forward_r_vld", 64'h0, 64'(fspu_forward_r_vld));
    // Open the whole pipe on the next falling edge
    @(negedge ex1_pipe_clk);
    ex1_pipedown = 1'b1;
    ex2_pipedown = 1'b1;
    ex3_pipedown = 1'b1;
    #10;
    check_val("fspu_forward_r_vld", 64'h1, 64'(fspu_forward_r_vld));
    tick();
  endtask

  task automatic test_sign_inject();
    logic [63:0] s0;
    logic [63:0] s1;
    logic [63:0] mv;
    for (int fmt = 0; fmt < 3; fmt++)
    begin
      for (int op = K_SGNJ; op <= K_SGNJX; op++)
      begin
        s0 = rand64();
        s1 = rand64();
        mv = rand64();
        drive_op(fmt, op, s0, s1, mv, '0);
        wait_forward(ref_freg(fmt, op, s0, s1, mv), 2);
      end
    end
  endtask

  // Back to back moves keep two results in flight
  task automatic test_move_fx();
    for (int fmt = 0; fmt < 3; fmt++)
    begin
      drive_op(fmt, K_FMV_FX, rand64(), rand64(), rand64(), '0);
      tick();
    end
    drive_op(0, K_NONE, '0, '0, '0, '0);
    tick();
    tick();
  endtask

  task automatic test_int_results();
    logic [63:0] s0;
    logic [63:0] sb;
    for (int fmt = 0; fmt < 3; fmt++)
    begin
      sb = 64'h1 << (fmt_width(fmt) - 1);
      // Both sign values for the extension
      for (int k = 0; k < 2; k++)
      begin
        s0 = (k == 0) ? (rand64() & ~sb) : (rand64() | sb);
        drive_op(fmt, K_FMV_XF, s0, rand64(), rand64(), ref_xf(fmt, s0));
        tick();
      end
      for (int i = 0; i < `FSPU_CLASS_W; i++)
      begin
        drive_op(fmt, K_FCLASS, make_fp(fmt, i, rand64()), rand64(), rand64(), 64'h1 << i);
        tick();
      end
    end
  endtask

  task automatic test_stall();
    logic [63:0] a0;
    logic [63:0] a1;
    logic [63:0] b0;
    logic [63:0] b1;
    a0 = rand64();
    a1 = rand64();
    b0 = rand64();
    b1 = rand64();
    // A enters EX2 while EX3 is frozen
    ex2_pipedown = 1'b0;
    drive_op(2, K_SGNJX, a0, a1, '0, '0);
    tick();
    // EX2 frozen too so B waits at the input
    ex1_pipedown = 1'b0;
    drive_op(1, K_SGNJN, b0, b1, '0, '0);
    repeat (3) tick();
    // EX3 released first and A moves out
    ex2_pipedown = 1'b1;
    tick();
    check_val("fspu_forward_result", ref_freg(2, K_SGNJX, a0, a1, '0), fspu_forward_result);
    ex1_pipedown = 1'b1;
    wait_forward(ref_freg(1, K_SGNJN, b0, b1, '0), 2);
  endtask

  initial
  begin
    errors       = 0;
    cpurst_b     = 1'b0;
    func         = '0;
    srcf0        = '0;
    srcf1        = '0;
    mtvr_src0    = '0;
    ex1_pipedown = 1'b0;
    ex2_pipedown = 1'b0;
    ex3_pipedown = 1'b0;
    exp_ex2      = '0;
    exp_ex3      = '0;
    cur_freg     = '0;
    test_reset();
    test_sign_inject();
    test_move_fx();
    test_int_results();
    test_stall();
    $display("Errors found: %0d", errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* rtl/fspu_top.sv */
//~~~~~~~~~~~~~~~~~~~~
// FSPU top level
// Decoder, three format lanes, result pipe
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "fspu_cfg.svh"

module fspu_top (
  input  logic                    ex1_pipe_clk,
  input  logic                    cpurst_b,
  input  logic [`FSPU_FUNC_W-1:0] dp_vfalu_ex1_pipex_func,
  input  logic [`FSPU_XLEN-1:0]   dp_vfalu_ex1_pipex_srcf0,
  input  logic [`FSPU_XLEN-1:0]   dp_vfalu_ex1_pipex_srcf1,
  input  logic [`FSPU_XLEN-1:0]   dp_vfalu_ex1_pipex_mtvr_src0,
  input  logic                    ex1_pipedown,
  input  logic                    ex2_pipedown,
  input  logic                    ex3_pipedown,
  output logic                    fspu_forward_r_vld,
  output logic [`FSPU_XLEN-1:0]   fspu_forward_result,
  output logic [`FSPU_XLEN-1:0]   fspu_mfvr_data
);

  import fspu_pkg::*;

  fspu_fmt_e             ex1_fmt;
  fspu_op_e              ex1_op;
  logic [`FSPU_XLEN-1:0] half_freg;
  logic [`FSPU_XLEN-1:0] sing_freg;
  logic [`FSPU_XLEN-1:0] doub_freg;
  logic [`FSPU_XLEN-1:0] half_int;
  logic [`FSPU_XLEN-1:0] sing_int;
  logic [`FSPU_XLEN-1:0] doub_int;

  // Shared decode for all lanes
  fspu_decode u_decode (
    .func (dp_vfalu_ex1_pipex_func),
    .fmt  (ex1_fmt),
    .op   (ex1_op)
  );

  // Lanes see same op, mux picks one
  fspu_fmt_lane #(.flt_t(fspu_half_t)) u_half_lane (
    .op          (ex1_op),
    .src0        (dp_vfalu_ex1_pipex_srcf0),
    .src1        (dp_vfalu_ex1_pipex_srcf1),
    .mtvr_src0   (dp_vfalu_ex1_pipex_mtvr_src0),
    .freg_result (half_freg),
    .int_result  (half_int)
  );

  fspu_fmt_lane #(.flt_t(fspu_sing_t)) u_sing_lane (
    .op          (ex1_op),
    .src0        (dp_vfalu_ex1_pipex_srcf0),
    .src1        (dp_vfalu_ex1_pipex_srcf1),
    .mtvr_src0   (dp_vfalu_ex1_pipex_mtvr_src0),
    .freg_result (sing_freg),
    .int_result  (sing_int)
  );

  fspu_fmt_lane #(.flt_t(fspu_doub_t)) u_doub_lane (
    .op          (ex1_op),
    .src0        (dp_vfalu_ex1_pipex_srcf0),
    .src1        (dp_vfalu_ex1_pipex_srcf1),
    .mtvr_src0   (dp_vfalu_ex1_pipex_mtvr_src0),
    .freg_result (doub_freg),
    .int_result  (doub_int)
  );

  // Format mux and EX2/EX3 registers
  fspu_result_pipe u_result_pipe (
    .ex1_pipe_clk        (ex1_pipe_clk),
    .cpurst_b            (cpurst_b),
    .fmt                 (ex1_fmt),
    .half_freg           (half_freg),
    .sing_freg           (sing_freg),
    .doub_freg           (doub_freg),
    .half_int            (half_int),
    .sing_int            (sing_int),
    .doub_int            (doub_int),
    .ex1_pipedown        (ex1_pipedown),
    .ex2_pipedown        (ex2_pipedown),
    .ex3_pipedown        (ex3_pipedown),
    .fspu_mfvr_data      (fspu_mfvr_data),
    .fspu_forward_result (fspu_forward_result),
    .fspu_forward_r_vld  (fspu_forward_r_vld)
  );

endmodule

/* rtl/fspu_result_pipe.sv */
//~~~~~~~~~~~~~~~~~~~~
// FSPU result select and pipe
// Lane mux by format
// Integer result out in EX1
// EX2 and EX3 float result registers
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "fspu_cfg.svh"

module fspu_result_pipe (
  input  logic                  ex1_pipe_clk,
  input  logic                  cpurst_b,
  input  fspu_pkg::fspu_fmt_e   fmt,
  input  logic [`FSPU_XLEN-1:0] half_freg,
  input  logic [`FSPU_XLEN-1:0] sing_freg,
  input  logic [`FSPU_XLEN-1:0] doub_freg,
  input  logic [`FSPU_XLEN-1:0] half_int,
  input  logic [`FSPU_XLEN-1:0] sing_int,
  input  logic [`FSPU_XLEN-1:0] doub_int,
  input  logic                  ex1_pipedown,
  input  logic                  ex2_pipedown,
  input  logic                  ex3_pipedown,
  output logic [`FSPU_XLEN-1:0] fspu_mfvr_data,
  output logic [`FSPU_XLEN-1:0] fspu_forward_result,
  output logic                  fspu_forward_r_vld
);

  import fspu_pkg::*;

  logic [`FSPU_XLEN-1:0] ex1_freg_result;
  logic [`FSPU_XLEN-1:0] ex2_result;
  logic [`FSPU_XLEN-1:0] ex3_result;

  // Pick the lane for this format
  always_comb
  begin
    case (fmt)
      FMT_DOUB:
      begin
        ex1_freg_result = doub_freg;
        fspu_mfvr_data  = doub_int;
      end
      FMT_SING:
      begin
        ex1_freg_result = sing_freg;
        fspu_mfvr_data  = sing_int;
      end
      default:
      begin
        ex1_freg_result = half_freg;
        fspu_mfvr_data  = half_int;
      end
    endcase
  end

  // EX2 stage, held while ex1_pipedown low
  always_ff @(posedge ex1_pipe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex2_result <= '0;
    else if (ex1_pipedown)
      ex2_result <= ex1_freg_result;
  end

  // EX3 stage
  always_ff @(posedge ex1_pipe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex3_result <= '0;
    else if (ex2_pipedown)
      ex3_result <= ex2_result;
  end

  // Forward from EX3
  assign fspu_forward_result = ex3_result;
  assign fspu_forward_r_vld  = ex3_pipedown;

endmodule

/* rtl/fspu_fmt_lane.sv */
//~~~~~~~~~~~~~~~~~~~~
// FSPU per-format lane
// Sign inject, FMV.F.X with NaN-boxing
// FMV.X.F with sign extension, FCLASS mask
// Float type chosen by parameter
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "fspu_cfg.svh"

module fspu_fmt_lane #(
  parameter type flt_t = fspu_pkg::fspu_doub_t
) (
  input  fspu_pkg::fspu_op_e    op,
  input  logic [`FSPU_XLEN-1:0] src0,
  input  logic [`FSPU_XLEN-1:0] src1,
  input  logic [`FSPU_XLEN-1:0] mtvr_src0,
  output logic [`FSPU_XLEN-1:0] freg_result,
  output logic [`FSPU_XLEN-1:0] int_result
);

  import fspu_pkg::*;

  // Format width from the struct
  localparam int W = $bits(flt_t);

  flt_t src0_f;
  flt_t src1_f;
  flt_t mtvr_f;
  flt_t res_f;
  logic res_vld;

  // Mantissa width, top bit marks quiet NaN
  localparam int MANT_W = $bits(src0_f.mant);

  logic exp_max;
  logic exp_zero;
  logic mant_zero;
  logic quiet_bit;
  logic is_inf;
  logic is_nan;
  logic is_zero;
  logic is_sub;
  logic is_norm;
  logic [`FSPU_CLASS_W-1:0] class_mask;

  // Low W bits viewed as float
  assign src0_f = src0[W-1:0];
  assign src1_f = src1[W-1:0];
  assign mtvr_f = mtvr_src0[W-1:0];

  // Sign injection and int to float move
  always_comb
  begin
    res_f   = src0_f;
    res_vld = 1'b1;
    case (op)
      OP_FSGNJ:  res_f.sign = src1_f.sign;
      OP_FSGNJN: res_f.sign = ~src1_f.sign;
      OP_FSGNJX: res_f.sign = src0_f.sign ^ src1_f.sign;
      OP_FMV_FX: res_f      = mtvr_f;
      default:   res_vld    = 1'b0;
    endcase
  end

  // NaN-box upper bits with ones
  always_comb
  begin
    freg_result = '0;
    if (res_vld)
    begin
      freg_result        = {`FSPU_XLEN{1'b1}};
      freg_result[W-1:0] = res_f;
    end
  end

  // Field checks on src0
  assign exp_max   = (src0_f.expo == '1);
  assign exp_zero  = (src0_f.expo == '0);
  assign mant_zero = (src0_f.mant == '0);
  assign quiet_bit = src0_f.mant[MANT_W-1];

  // Categories, exactly one true
  assign is_inf  = exp_max && mant_zero;
  assign is_nan  = exp_max && !mant_zero;
  assign is_zero = exp_zero && mant_zero;
  assign is_sub  = exp_zero && !mant_zero;
  assign is_norm = !exp_zero && !exp_max;

  // Class mask, bit 0 is -inf up to bit 9 qNaN
  assign class_mask = {
    is_nan && quiet_bit,
    is_nan && !quiet_bit,
    !src0_f.sign && is_inf,
    !src0_f.sign && is_norm,
    !src0_f.sign && is_sub,
    !src0_f.sign && is_zero,
    src0_f.sign && is_zero,
    src0_f.sign && is_sub,
    src0_f.sign && is_norm,
    src0_f.sign && is_inf
  };

  // Integer side result
  always_comb
  begin
    int_result = '0;
    case (op)
      OP_FMV_XF:
      begin
        // Sign extend the raw float bits
        int_result        = {`FSPU_XLEN{src0_f.sign}};
        int_result[W-1:0] = src0_f;
      end
      OP_FCLASS:
        int_result[`FSPU_CLASS_W-1:0] = class_mask;
      default:
        int_result = '0;
    endcase
  end

endmodule

/* rtl/fspu_decode.sv */
//~~~~~~~~~~~~~~~~~~~~
// FSPU func decoder
// One-hot func fields to format and operation
// Combinational only
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "fspu_cfg.svh"

module fspu_decode (
  input  logic [`FSPU_FUNC_W-1:0] func,
  output fspu_pkg::fspu_fmt_e     fmt,
  output fspu_pkg::fspu_op_e      op
);

  import fspu_pkg::*;

  logic grp_sgnj;
  logic grp_mv;

  // Group bits
  assign grp_sgnj = func[`FSPU_FUNC_SGNJ_GRP];
  assign grp_mv   = func[`FSPU_FUNC_MV_GRP];

  // Double wins over single, half when neither set
  always_comb
  begin
    if (func[`FSPU_FUNC_DOUBLE])
      fmt = FMT_DOUB;
    else if (func[`FSPU_FUNC_SINGLE])
      fmt = FMT_SING;
    else
      fmt = FMT_HALF;
  end

  // Prioritized op select
  // Class first, then moves, then sign inject
  always_comb
  begin
    if (func[`FSPU_FUNC_CLASS])
      op = OP_FCLASS;
    else if (grp_mv && func[`FSPU_FUNC_SEL2])
      op = OP_FMV_XF;
    else if (grp_mv && func[`FSPU_FUNC_SEL0])
      op = OP_FMV_FX;
    else if (grp_sgnj && func[`FSPU_FUNC_SEL2])
      op = OP_FSGNJX;
    else if (grp_sgnj && func[`FSPU_FUNC_SEL1])
      op = OP_FSGNJN;
    else if (grp_sgnj && func[`FSPU_FUNC_SEL0])
      op = OP_FSGNJ;
    else
      // Unknown func, lanes output zero
      op = OP_NONE;
  end

endmodule

/* rtl/fspu_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~
// FSPU shared types
// Half, single and double float structs
// Operand format and operation enums
//~~~~~~~~~~~~~~~~~~~~
package fspu_pkg;

  // Half precision, 1/5/10
  typedef struct packed {
    logic        sign;
    logic [4:0]  expo;
    logic [9:0]  mant;
  } fspu_half_t;

  // Single precision, 1/8/23
  typedef struct packed {
    logic        sign;
    logic [7:0]  expo;
    logic [22:0] mant;
  } fspu_sing_t;

  // Double precision, 1/11/52
  typedef struct packed {
    logic        sign;
    logic [10:0] expo;
    logic [51:0] mant;
  } fspu_doub_t;

  // Operand format from func
  typedef enum logic [1:0] {
    FMT_HALF = 2'd0,
    FMT_SING = 2'd1,
    FMT_DOUB = 2'd2
  } fspu_fmt_e;

  // Decoded operation
  typedef enum logic [2:0] {
    OP_NONE   = 3'd0,
    OP_FSGNJ  = 3'd1,
    OP_FSGNJN = 3'd2,
    OP_FSGNJX = 3'd3,
    OP_FMV_FX = 3'd4,
    OP_FMV_XF = 3'd5,
    OP_FCLASS = 3'd6
  } fspu_op_e;

endpackage

/* rtl/fspu_cfg.svh */
//~~~~~~~~~~~~~~~~~~~~
// Shared widths for the FSPU
// Data path width, func word width
// Func field bit positions
// Class mask width
//~~~~~~~~~~~~~~~~~~~~
`ifndef FSPU_CFG_SVH
`define FSPU_CFG_SVH

// Data path and func word
`define FSPU_XLEN          64
`define FSPU_FUNC_W        20

// Format bits, neither set means half
`define FSPU_FUNC_DOUBLE   16
`define FSPU_FUNC_SINGLE   15

// Operation group bits
`define FSPU_FUNC_SGNJ_GRP 6
`define FSPU_FUNC_MV_GRP   5

// Selector bits within a group
`define FSPU_FUNC_SEL0     0
`define FSPU_FUNC_SEL1     1
`define FSPU_FUNC_SEL2     2
`define FSPU_FUNC_CLASS    18

// One bit per FCLASS category
`define FSPU_CLASS_W       10

`endif
